// ==== flist.f ====
design/cache_ctrl_pkg.sv
design/cache_tag_store.sv
design/write_through_buffer.sv
design/cache_control.sv
design/cache_monitor_top.sv
verif/tb_clock_gen.sv
verif/cache_monitor_tb.sv

// ==== verif/cache_monitor_tb.sv ====
// Cache monitor testbench: random and directed stimulus, tag reference model,
// write-through scoreboard, protocol assertions and watchdog

`timescale 1ns/1ps

module cache_monitor_tb;

   import cache_ctrl_pkg::*;

   localparam int IDX_W       = 3;
   localparam int WTB_DEPTH_W = 2;
   localparam int LINES       = 2 ** IDX_W;
   localparam int DEPTH       = 2 ** WTB_DEPTH_W;
   localparam int N_ACC       = 200;
   localparam int N_ACC_ALL   = N_ACC + 40;   // Random run plus directed traffic
   localparam int CLK_NS      = 100;

   logic       clk_i;
   logic       arst_i;
   logic       acc_valid_i;
   logic       acc_we_i;
   word_addr_t acc_addr_i;
   data_t      acc_wdata_i;
   logic       mem_ready_i;
   logic       mem_valid_o;
   wtb_entry_t mem_entry_o;
   logic       csr_valid_i;
   csr_addr_t  csr_addr_i;
   data_t      csr_rdata_o;
   logic       csr_ready_o;

   // Reference model of tags, counts and buffer occupancy
   logic [LINES-1:0] ref_valid = '0;
   word_addr_t       ref_tag [LINES];
   cnt_t             exp_rh = '0;
   cnt_t             exp_rm = '0;
   cnt_t             exp_wh = '0;
   cnt_t             exp_wm = '0;
   int               model_occ = 0;
   logic             inv_pending = 1'b0;
   logic             hold_prev = 1'b0;
   wtb_entry_t       entry_prev;
   wtb_entry_t       sb_q [$];
   int               seed;
   int               err_cnt = 0;

   tb_clock_gen #(.PERIOD_NS(CLK_NS), .RST_CYCLES(2)) u_clk_gen (.clk_o(clk_i), .arst_o(arst_i));

   cache_monitor_top #(
      .IDX_W      (IDX_W),
      .WTB_DEPTH_W(WTB_DEPTH_W)
   ) dut (
      .clk_i      (clk_i),
      .arst_i     (arst_i),
      .acc_valid_i(acc_valid_i),
      .acc_we_i   (acc_we_i),
      .acc_addr_i (acc_addr_i),
      .acc_wdata_i(acc_wdata_i),
      .mem_ready_i(mem_ready_i),
      .mem_valid_o(mem_valid_o),
      .mem_entry_o(mem_entry_o),
      .csr_valid_i(csr_valid_i),
      .csr_addr_i (csr_addr_i),
      .csr_rdata_o(csr_rdata_o),
      .csr_ready_o(csr_ready_o)
   );

   task automatic report_mismatch(input string name, input logic [63:0] exp,
                                  input logic [63:0] act);
      err_cnt++;
      $display("CHECK FAILED at %0t ns: %s expected %0h, got %0h", $time, name, exp, act);
      $display("Simulation failed");
      $fatal(1, "Stopping at first error");
   endtask

   task automatic abort_run(input string why);
      err_cnt++;
      $display("Error at %0t ns: %s", $time, why);
      $display("Simulation failed");
      $fatal(1, "Stopping at first error");
   endtask

   // ********************
   // Protocol assertions
   // ********************
   assert property (@(posedge clk_i) disable iff (arst_i) csr_valid_i |=> csr_ready_o)
      else report_mismatch("csr_ready_o", 1, 0);
   assert property (@(posedge clk_i) disable iff (arst_i) !csr_valid_i |=> !csr_ready_o)
      else report_mismatch("csr_ready_o", 0, 1);
   assert property (@(posedge clk_i) disable iff (arst_i) !csr_ready_o |-> csr_rdata_o == '0)
      else report_mismatch("csr_rdata_o", 0, $sampled(csr_rdata_o));

   // ********************
   // Reference model
   // ********************

   // Inputs and outputs are stable here, so each negedge predicts the next rising edge
   always @(negedge clk_i) begin : ref_model
      logic [IDX_W-1:0] idx;
      logic             hit;
      logic             pop;
      logic             push;
      if (arst_i !== 1'b0) begin
         ref_valid   = '0;
         exp_rh      = '0;
         exp_rm      = '0;
         exp_wh      = '0;
         exp_wm      = '0;
         model_occ   = 0;
         inv_pending = 1'b0;
         hold_prev   = 1'b0;
         sb_q.delete();
      end else begin
         if (hold_prev) begin  // Stalled head must not move
            assert (mem_valid_o === 1'b1) else report_mismatch("mem_valid_o", 1, mem_valid_o);
            assert (mem_entry_o === entry_prev)
               else report_mismatch("mem_entry_o", entry_prev, mem_entry_o);
         end
         assert (mem_valid_o === (model_occ != 0))
            else report_mismatch("mem_valid_o", model_occ != 0, mem_valid_o);
         pop  = (model_occ != 0) && mem_ready_i;
         push = acc_valid_i && acc_we_i && (model_occ < DEPTH);
         if (pop) begin
            assert (mem_entry_o === sb_q[0])
               else report_mismatch("mem_entry_o", sb_q[0], mem_entry_o);
            void'(sb_q.pop_front());
         end
         if (push) begin
            sb_q.push_back({acc_addr_i, acc_wdata_i});
         end
         model_occ  = model_occ + int'(push) - int'(pop);
         hold_prev  = mem_valid_o && !mem_ready_i;
         entry_prev = mem_entry_o;

         idx = acc_addr_i[IDX_W-1:0];
         hit = ref_valid[idx] && (ref_tag[idx] == (acc_addr_i >> IDX_W));
         if (csr_valid_i && csr_addr_i == CSR_RST_CNTRS) begin
            exp_rh = '0;  // Wipes this access too, its count lands on the reset edge
            exp_rm = '0;
            exp_wh = '0;
            exp_wm = '0;
         end else if (acc_valid_i) begin
            case ({acc_we_i, hit})
               2'b00:   exp_rm++;
               2'b01:   exp_rh++;
               2'b10:   exp_wm++;
               default: exp_wh++;
            endcase
         end
         if (inv_pending) begin
            ref_valid = '0;
         end else if (acc_valid_i && !acc_we_i && !hit) begin
            ref_valid[idx] = 1'b1;
            ref_tag[idx]   = acc_addr_i >> IDX_W;
         end
         inv_pending = csr_valid_i && (csr_addr_i == CSR_INVALIDATE);
      end
   end

   // ********************
   // Stimulus tasks
   // ********************
   task automatic access(input logic valid, input logic we, input word_addr_t addr,
                         input data_t wdata);
      @(posedge clk_i);
      acc_valid_i <= valid;
      acc_we_i    <= we;
      acc_addr_i  <= addr;
      acc_wdata_i <= wdata;
   endtask

   task automatic quiet(input int cycles);
      repeat (cycles) access(1'b0, 1'b0, '0, '0);
   endtask

   task automatic csr_read(input csr_addr_t addr, output data_t rdata);
      @(posedge clk_i);
      acc_valid_i <= 1'b0;
      csr_valid_i <= 1'b1;
      csr_addr_i  <= addr;
      @(posedge clk_i);
      csr_valid_i <= 1'b0;
      @(negedge clk_i);
      rdata = csr_rdata_o;
   endtask

   task automatic check_csr(input csr_addr_t addr, input data_t exp);
      data_t got;
      csr_read(addr, got);
      assert (got === exp)
         else report_mismatch($sformatf("csr_rdata_o at address %0d", addr), exp, got);
   endtask

   task automatic check_counters();
      check_csr(CSR_READ_HIT, exp_rh);
      check_csr(CSR_READ_MISS, exp_rm);
      check_csr(CSR_WRITE_HIT, exp_wh);
      check_csr(CSR_WRITE_MISS, exp_wm);
      check_csr(CSR_RW_HIT, exp_rh + exp_wh);
      check_csr(CSR_RW_MISS, exp_rm + exp_wm);
   endtask

   // Memory accepts with random stalls until the buffer runs empty
   task automatic drain();
      int r;
      do begin
         r = $random(seed);
         @(posedge clk_i);
         mem_ready_i <= r[0] || r[1];
         @(negedge clk_i);
      end while (mem_valid_o);
   endtask

   // ********************
   // Test sequence
   // ********************
   initial begin
      data_t      miss_before;
      word_addr_t addr;
      int         r;
      acc_valid_i = 1'b0;
      acc_we_i    = 1'b0;
      acc_addr_i  = '0;
      acc_wdata_i = '0;
      mem_ready_i = 1'b1;
      csr_valid_i = 1'b0;
      csr_addr_i  = '0;
      seed        = 32'hf2cd_ab3f;
      @(negedge arst_i);
      @(negedge clk_i);

      assert (csr_ready_o === 1'b0) else report_mismatch("csr_ready_o", 0, csr_ready_o);
      assert (mem_valid_o === 1'b0) else report_mismatch("mem_valid_o", 0, mem_valid_o);
      for (int a = 0; a <= 5; a++) check_csr(csr_addr_t'(a), '0);
      check_csr(CSR_WTB_EMPTY, 32'd1);
      check_csr(CSR_WTB_FULL, '0);
      check_csr(CSR_VERSION, CACHE_VERSION);
      for (int a = 11; a < 16; a++) check_csr(csr_addr_t'(a), '0);  // Unmapped
      check_csr(CSR_RST_CNTRS, '0);
      check_csr(CSR_INVALIDATE, '0);

      // Random reads and writes over 4 tags per line
      for (int i = 0; i < N_ACC; i++) begin
         r = $random(seed);
         access(r[12:10] != 3'd0, r[8], word_addr_t'(r[4:0]), $random(seed));
         mem_ready_i <= r[16] || r[17];
      end
      quiet(3);
      check_counters();
      drain();

      addr = 32'h0000_0015;
      access(1'b1, 1'b0, addr, '0);
      access(1'b1, 1'b0, addr, '0);
      quiet(3);
      miss_before = exp_rm;
      check_csr(CSR_INVALIDATE, '0);
      access(1'b1, 1'b0, addr, '0);  // Line was valid, now misses
      quiet(3);
      check_csr(CSR_READ_MISS, miss_before + 1);
      check_counters();
      check_csr(CSR_RST_CNTRS, '0);
      for (int a = 0; a <= 5; a++) check_csr(csr_addr_t'(a), '0);

      // Fill the buffer with memory stalled, one write too many
      for (int i = 0; i < DEPTH + 1; i++) begin
         access(1'b1, 1'b1, word_addr_t'(32'h100 + i), $random(seed));
         mem_ready_i <= 1'b0;
      end
      quiet(2);
      check_csr(CSR_WTB_FULL, 32'd1);
      check_csr(CSR_WTB_EMPTY, '0);
      drain();
      quiet(1);
      check_csr(CSR_WTB_EMPTY, 32'd1);
      check_csr(CSR_WTB_FULL, '0);
      if (sb_q.size() != 0) begin
         abort_run("accepted writes never reached the memory port");
      end
      check_counters();

      if (err_cnt == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

   // Watchdog, 10 cycles per access
   initial begin
      #(N_ACC_ALL * 10 * CLK_NS);
      $display("Timeout: the test sequence did not finish in time");
      $display("Simulation failed");
      $fatal(1, "Watchdog expired");
   end

endmodule

// ==== verif/tb_clock_gen.sv ====
// Testbench clock and reset source

`timescale 1ns/1ps

module tb_clock_gen #(
   parameter int PERIOD_NS  = 100,
   parameter int RST_CYCLES = 2
) (
   output logic clk_o,
   output logic arst_o
);

   initial begin
      clk_o = 1'b0;
      forever #(PERIOD_NS / 2) clk_o = ~clk_o;
   end

   // Reset spans the first rising edges
   initial begin
      arst_o = 1'b1;
      repeat (RST_CYCLES) @(posedge clk_o);
      arst_o <= 1'b0;
   end

endmodule

// ==== design/cache_monitor_top.sv ====
// Cache monitor top level: tag store, write-through buffer
// and controller with their interconnect

`timescale 1ns/1ps

module cache_monitor_top #(
   parameter int IDX_W       = 3,
   parameter int WTB_DEPTH_W = 2
) (
   input  logic                       clk_i,
   input  logic                       arst_i,
   // Access port
   input  logic                       acc_valid_i,
   input  logic                       acc_we_i,
   input  cache_ctrl_pkg::word_addr_t acc_addr_i,
   input  cache_ctrl_pkg::data_t      acc_wdata_i,
   // Memory port
   input  logic                       mem_ready_i,
   output logic                       mem_valid_o,
   output cache_ctrl_pkg::wtb_entry_t mem_entry_o,
   // Control port
   input  logic                       csr_valid_i,
   input  cache_ctrl_pkg::csr_addr_t  csr_addr_i,
   output cache_ctrl_pkg::data_t      csr_rdata_o,
   output logic                       csr_ready_o
);

   import cache_ctrl_pkg::*;

   acc_event_t  acc_event;
   wtb_status_t wtb_status;
   wtb_entry_t  wtb_push_entry;
   logic        wtb_push;
   logic        invalidate;

   assign wtb_push            = acc_valid_i && acc_we_i;  // Every write goes through
   assign wtb_push_entry.addr = acc_addr_i;
   assign wtb_push_entry.data = acc_wdata_i;

   cache_tag_store #(
      .IDX_W(IDX_W)
   ) u_tag_store (
      .clk_i       (clk_i),
      .arst_i      (arst_i),
      .acc_valid_i (acc_valid_i),
      .acc_we_i    (acc_we_i),
      .acc_addr_i  (acc_addr_i),
      .invalidate_i(invalidate),
      .event_o     (acc_event)
   );

   write_through_buffer #(
      .WTB_DEPTH_W(WTB_DEPTH_W)
   ) u_wtb (
      .clk_i       (clk_i),
      .arst_i      (arst_i),
      .push_i      (wtb_push),
      .push_entry_i(wtb_push_entry),
      .mem_ready_i (mem_ready_i),
      .mem_valid_o (mem_valid_o),
      .mem_entry_o (mem_entry_o),
      .status_o    (wtb_status)
   );

   cache_control u_control (
      .clk_i       (clk_i),
      .arst_i      (arst_i),
      .event_i     (acc_event),
      .wtb_status_i(wtb_status),
      .csr_valid_i (csr_valid_i),
      .csr_addr_i  (csr_addr_i),
      .csr_rdata_o (csr_rdata_o),
      .csr_ready_o (csr_ready_o),
      .invalidate_o(invalidate)
   );

endmodule

// ==== design/cache_control.sv ====
// Cache controller: event counters, control register decode,
// invalidate and counter-reset pulses

`timescale 1ns/1ps

module cache_control (
   input  logic                        clk_i,
   input  logic                        arst_i,
   input  cache_ctrl_pkg::acc_event_t  event_i,
   input  cache_ctrl_pkg::wtb_status_t wtb_status_i,
   input  logic                        csr_valid_i,
   input  cache_ctrl_pkg::csr_addr_t   csr_addr_i,
   output cache_ctrl_pkg::data_t       csr_rdata_o,
   output logic                        csr_ready_o,
   output logic                        invalidate_o
);

   import cache_ctrl_pkg::*;

   cnt_t read_hit_cnt_q;
   cnt_t read_miss_cnt_q;
   cnt_t write_hit_cnt_q;
   cnt_t write_miss_cnt_q;

   data_t rdata_q;
   data_t rdata_d;
   logic  ready_q;
   logic  invalidate_q;
   logic  invalidate_d;
   logic  rst_cntrs_q;
   logic  rst_cntrs_d;

   // ********************
   // Event counters
   // ********************

   // Counter reset beats an event in the same cycle
   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         read_hit_cnt_q   <= '0;
         read_miss_cnt_q  <= '0;
         write_hit_cnt_q  <= '0;
         write_miss_cnt_q <= '0;
      end else if (rst_cntrs_q) begin
         read_hit_cnt_q   <= '0;
         read_miss_cnt_q  <= '0;
         write_hit_cnt_q  <= '0;
         write_miss_cnt_q <= '0;
      end else begin
         if (event_i.read_hit) begin
            read_hit_cnt_q <= read_hit_cnt_q + 1'b1;    // Wraps on overflow
         end
         if (event_i.read_miss) begin
            read_miss_cnt_q <= read_miss_cnt_q + 1'b1;
         end
         if (event_i.write_hit) begin
            write_hit_cnt_q <= write_hit_cnt_q + 1'b1;
         end
         if (event_i.write_miss) begin
            write_miss_cnt_q <= write_miss_cnt_q + 1'b1;
         end
      end
   end

   // ********************
   // Register decode
   // ********************
   always_comb begin
      rdata_d      = '0;
      invalidate_d = 1'b0;
      rst_cntrs_d  = 1'b0;
      if (csr_valid_i) begin
         case (csr_addr_i)
            CSR_RW_HIT:     rdata_d = read_hit_cnt_q + write_hit_cnt_q;
            CSR_RW_MISS:    rdata_d = read_miss_cnt_q + write_miss_cnt_q;
            CSR_READ_HIT:   rdata_d = read_hit_cnt_q;
            CSR_READ_MISS:  rdata_d = read_miss_cnt_q;
            CSR_WRITE_HIT:  rdata_d = write_hit_cnt_q;
            CSR_WRITE_MISS: rdata_d = write_miss_cnt_q;
            CSR_RST_CNTRS:  rst_cntrs_d = 1'b1;
            CSR_INVALIDATE: invalidate_d = 1'b1;
            CSR_WTB_EMPTY:  rdata_d = data_t'(wtb_status_i.empty);
            CSR_WTB_FULL:   rdata_d = data_t'(wtb_status_i.full);
            CSR_VERSION:    rdata_d = CACHE_VERSION;
            default:        rdata_d = '0;  // Unmapped
         endcase
      end
   end

   // Reply and pulses all land one cycle after the request
   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         rdata_q      <= '0;
         ready_q      <= 1'b0;
         invalidate_q <= 1'b0;
         rst_cntrs_q  <= 1'b0;
      end else begin
         rdata_q      <= rdata_d;
         ready_q      <= csr_valid_i;
         invalidate_q <= invalidate_d;
         rst_cntrs_q  <= rst_cntrs_d;
      end
   end

   assign csr_rdata_o  = rdata_q;
   assign csr_ready_o  = ready_q;
   assign invalidate_o = invalidate_q;

endmodule

// ==== design/write_through_buffer.sv ====
// Write-through buffer: circular FIFO of address/data pairs,
// memory-side valid/ready drain, registered empty and full flags

`timescale 1ns/1ps

module write_through_buffer #(
   parameter int WTB_DEPTH_W = 2
) (
   input  logic                        clk_i,
   input  logic                        arst_i,
   input  logic                        push_i,
   input  cache_ctrl_pkg::wtb_entry_t  push_entry_i,
   input  logic                        mem_ready_i,
   output logic                        mem_valid_o,
   output cache_ctrl_pkg::wtb_entry_t  mem_entry_o,
   output cache_ctrl_pkg::wtb_status_t status_o
);

   import cache_ctrl_pkg::*;

   localparam int DEPTH = 2 ** WTB_DEPTH_W;

   typedef logic [WTB_DEPTH_W-1:0] ptr_t;
   typedef logic [WTB_DEPTH_W:0]   occ_t;

   localparam occ_t FULL_OCC = occ_t'(DEPTH);

   wtb_entry_t mem_q [DEPTH];
   ptr_t       wr_ptr_q;
   ptr_t       rd_ptr_q;
   occ_t       occ_q;
   occ_t       occ_d;
   logic       empty_q;
   logic       full_q;

   logic push_ok;
   logic pop;

   assign push_ok = push_i && !full_q;         // Dropped while full
   assign pop     = mem_valid_o && mem_ready_i;

   // ********************
   // Occupancy
   // ********************
   always_comb begin
      occ_d = occ_q;
      if (push_ok && !pop) begin
         occ_d = occ_q + 1'b1;
      end else if (pop && !push_ok) begin
         occ_d = occ_q - 1'b1;
      end
   end

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         occ_q    <= '0;
         empty_q  <= 1'b1;
         full_q   <= 1'b0;
      end else begin
         if (push_ok) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;  // Wraps at DEPTH
         end
         if (pop) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         occ_q   <= occ_d;
         empty_q <= (occ_d == '0);
         full_q  <= (occ_d == FULL_OCC);
      end
   end

   // ********************
   // Storage
   // ********************
   always_ff @(posedge clk_i) begin
      if (push_ok) begin
         mem_q[wr_ptr_q] <= push_entry_i;
      end
   end

   // Head entry holds until it is popped
   assign mem_valid_o = !empty_q;
   assign mem_entry_o = mem_q[rd_ptr_q];

   always_comb begin
      status_o       = '0;
      status_o.empty = empty_q;
      status_o.full  = full_q;
   end

endmodule

// ==== design/cache_tag_store.sv ====
// Direct-mapped tag store: valid bits and tags per line,
// access classifier and flash invalidate

`timescale 1ns/1ps

module cache_tag_store #(
   parameter int IDX_W = 3
) (
   input  logic                       clk_i,
   input  logic                       arst_i,
   input  logic                       acc_valid_i,
   input  logic                       acc_we_i,
   input  cache_ctrl_pkg::word_addr_t acc_addr_i,
   input  logic                       invalidate_i,
   output cache_ctrl_pkg::acc_event_t event_o
);

   import cache_ctrl_pkg::*;

   localparam int LINES = 2 ** IDX_W;
   localparam int TAG_W = $bits(word_addr_t) - IDX_W;

   typedef logic [IDX_W-1:0] idx_t;
   typedef logic [TAG_W-1:0] tag_t;

   logic [LINES-1:0] valid_q;
   tag_t             tag_q [LINES];
   acc_event_t       event_q;

   idx_t       acc_idx;
   tag_t       acc_tag;
   logic       hit;
   logic       rd_miss;
   acc_event_t event_d;

   assign acc_idx = acc_addr_i[IDX_W-1:0];
   assign acc_tag = acc_addr_i[$bits(word_addr_t)-1:IDX_W];

   // Compare against the indexed line only
   assign hit = valid_q[acc_idx] && (tag_q[acc_idx] == acc_tag);

   // ********************
   // Classifier
   // ********************
   always_comb begin
      event_d            = '0;
      event_d.read_hit   = acc_valid_i && !acc_we_i && hit;
      event_d.read_miss  = acc_valid_i && !acc_we_i && !hit;
      event_d.write_hit  = acc_valid_i && acc_we_i && hit;
      event_d.write_miss = acc_valid_i && acc_we_i && !hit;
   end

   assign rd_miss = event_d.read_miss;  // Only read misses allocate

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         event_q <= '0;
      end else begin
         event_q <= event_d;
      end
   end

   // ********************
   // Line state
   // ********************

   // Invalidate wins over an allocation in the same cycle
   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         valid_q <= '0;
      end else if (invalidate_i) begin
         valid_q <= '0;
      end else if (rd_miss) begin
         valid_q[acc_idx] <= 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rd_miss) begin
         tag_q[acc_idx] <= acc_tag;
      end
   end

   assign event_o = event_q;

endmodule

// ==== design/cache_ctrl_pkg.sv ====
// Shared types of the cache monitor: widths, event and buffer structs,
// control register map and version constant

package cache_ctrl_pkg;

   // ********************
   // Widths
   // ********************
   typedef logic [31:0] word_addr_t;
   typedef logic [31:0] data_t;
   typedef logic [31:0] cnt_t;
   typedef logic [3:0]  csr_addr_t;

   // ********************
   // Structs
   // ********************

   // One flag per classified access, never more than one set
   typedef struct packed {
      logic read_hit;
      logic read_miss;
      logic write_hit;
      logic write_miss;
   } acc_event_t;

   // One buffered write toward memory
   typedef struct packed {
      word_addr_t addr;
      data_t      data;
   } wtb_entry_t;

   typedef struct packed {
      logic empty;
      logic full;
   } wtb_status_t;

   // ********************
   // Register map
   // ********************
   localparam csr_addr_t CSR_RW_HIT     = 4'd0;   // Read hits + write hits
   localparam csr_addr_t CSR_RW_MISS    = 4'd1;   // Read misses + write misses
   localparam csr_addr_t CSR_READ_HIT   = 4'd2;
   localparam csr_addr_t CSR_READ_MISS  = 4'd3;
   localparam csr_addr_t CSR_WRITE_HIT  = 4'd4;
   localparam csr_addr_t CSR_WRITE_MISS = 4'd5;
   localparam csr_addr_t CSR_RST_CNTRS  = 4'd6;   // Pulse, reads zero
   localparam csr_addr_t CSR_INVALIDATE = 4'd7;   // Pulse, reads zero
   localparam csr_addr_t CSR_WTB_EMPTY  = 4'd8;
   localparam csr_addr_t CSR_WTB_FULL   = 4'd9;
   localparam csr_addr_t CSR_VERSION    = 4'd10;

   localparam data_t CACHE_VERSION = 32'h0001_0200;

endpackage
